// File: dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LINE_W = 128;
    localparam int NWAY = 2;
    localparam int NSET = 256;
    localparam int OFFSET_W = $clog2(LINE_W / 8);
    localparam int INDEX_W = $clog2(NSET);
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WB_DEPTH = 4;

    typedef logic [LINE_W-1:0] line_t;

    // dirty and valid sit above the tag in a 22-bit entry
    typedef struct packed {
        logic dirty;
        logic valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        REFILL_REQ,
        REFILL_WAIT
    } ctrl_state_e;

    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [INDEX_W-1:0] addr_index(input logic [ADDR_W-1:0] a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    // word number inside the line
    function automatic logic [OFFSET_W-3:0] addr_word(input logic [ADDR_W-1:0] a);
        return a[OFFSET_W-1:2];
    endfunction

    function automatic logic [ADDR_W-1:0] line_addr(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

endpackage

// File: wb_if.sv
`timescale 1ns/1ps

interface wb_if;
    import dcache_pkg::*;

    // victim push from the controller
    logic push;
    logic [ADDR_W-1:0] push_addr;
    line_t push_data;
    logic full;

    // head of the writeback buffer
    logic head_valid;
    logic [ADDR_W-1:0] head_addr;
    line_t head_data;
    logic pop;

    // refill read whose request is held until the data returns
    logic refill_req;
    logic [ADDR_W-1:0] refill_addr;
    logic refill_valid;
    line_t refill_data;

    modport ctrl (
        output push, push_addr, push_data, refill_req, refill_addr,
        input  full, head_valid, refill_valid, refill_data
    );

    modport fifo (
        input  push, push_addr, push_data, pop,
        output full, head_valid, head_addr, head_data
    );

    modport port (
        input  head_valid, head_addr, head_data, refill_req, refill_addr,
        output pop, refill_valid, refill_data
    );

endinterface

// File: cache_store.sv
`timescale 1ns/1ps

module cache_store #(
    parameter int NWAY = dcache_pkg::NWAY,
    parameter int NSET = dcache_pkg::NSET
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [$clog2(NSET)-1:0]             rd_index_i,
    output dcache_pkg::tag_entry_t [NWAY-1:0]   tag_rd_o,
    output dcache_pkg::line_t [NWAY-1:0]        line_rd_o,
    input  logic                                wr_way_i,
    input  logic [$clog2(NSET)-1:0]             wr_index_i,
    input  logic                                tag_we_i,
    input  dcache_pkg::tag_entry_t              tag_wr_i,
    input  logic [dcache_pkg::LINE_W/8-1:0]     byte_we_i,
    input  dcache_pkg::line_t                   line_wr_i,
    output logic                                init_done_o
);
    import dcache_pkg::*;

    tag_entry_t tag_mem [NWAY][NSET];
    line_t data_mem [NWAY][NSET];
    logic [$clog2(NSET)-1:0] sweep_idx;
    logic init_done;

    assign init_done_o = init_done;

    // one set per cycle is cleared after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_idx <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == $clog2(NSET)'(NSET - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NWAY; w++) begin
            tag_rd_o[w] <= tag_mem[w][rd_index_i];
            line_rd_o[w] <= data_mem[w][rd_index_i];
            if (!init_done) begin
                tag_mem[w][sweep_idx] <= '0;
            end else if (tag_we_i && w == int'(wr_way_i)) begin
                tag_mem[w][wr_index_i] <= tag_wr_i;
            end
            // only the selected way takes the enabled bytes
            for (int b = 0; b < LINE_W / 8; b++) begin
                if (byte_we_i[b] && w == int'(wr_way_i)) begin
                    data_mem[w][wr_index_i][8*b +: 8] <= line_wr_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        valid_i,
    input  logic [dcache_pkg::ADDR_W-1:0]               addr_i,
    input  logic [3:0]                                  wstrb_i,
    input  logic [dcache_pkg::DATA_W-1:0]               wdata_i,
    output logic                                        data_ok_o,
    output logic [dcache_pkg::DATA_W-1:0]               rdata_o,
    output logic [dcache_pkg::INDEX_W-1:0]              rd_index_o,
    input  dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0] tag_rd_i,
    input  dcache_pkg::line_t [dcache_pkg::NWAY-1:0]    line_rd_i,
    output logic                                        wr_way_o,
    output logic [dcache_pkg::INDEX_W-1:0]              wr_index_o,
    output logic                                        tag_we_o,
    output dcache_pkg::tag_entry_t                      tag_wr_o,
    output logic [dcache_pkg::LINE_W/8-1:0]             byte_we_o,
    output dcache_pkg::line_t                           line_wr_o,
    input  logic                                        init_done_i,
    wb_if.ctrl                                          wb
);
    import dcache_pkg::*;

    ctrl_state_e state;
    logic [ADDR_W-1:0] req_addr;
    logic [3:0] req_wstrb;
    logic [DATA_W-1:0] req_wdata;
    logic victim_way;
    logic [15:0] lfsr;
    logic [NWAY-1:0] way_hit;
    logic hit;
    logic hit_way;
    logic is_store;
    logic victim_dirty;
    tag_entry_t victim_tag;
    line_t hit_line;
    line_t store_line;
    line_t merged_line;
    logic [LINE_W/8-1:0] store_be;
    logic [OFFSET_W-3:0] word_sel;

    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            way_hit[w] = tag_rd_i[w].valid && tag_rd_i[w].tag == addr_tag(req_addr);
        end
    end

    assign hit = |way_hit;
    assign hit_way = way_hit[1];
    assign hit_line = line_rd_i[hit_way];
    assign is_store = req_wstrb != 4'b0;
    assign word_sel = addr_word(req_addr);
    assign store_be = (LINE_W / 8)'(req_wstrb) << (4 * word_sel);
    assign store_line = {(LINE_W / DATA_W){req_wdata}};

    // store bytes overlay the refilled line
    always_comb begin
        for (int b = 0; b < LINE_W / 8; b++) begin
            merged_line[8*b +: 8] = store_be[b] ? store_line[8*b +: 8]
                                                : wb.refill_data[8*b +: 8];
        end
    end

    assign victim_tag = tag_rd_i[victim_way];
    assign victim_dirty = victim_tag.valid && victim_tag.dirty;

    // arrays follow the request set once a lookup starts
    assign rd_index_o = (state == IDLE) ? addr_index(addr_i) : addr_index(req_addr);
    assign wr_index_o = addr_index(req_addr);

    always_comb begin
        wr_way_o = victim_way;
        tag_we_o = 1'b0;
        tag_wr_o = '{dirty: is_store, valid: 1'b1, tag: addr_tag(req_addr)};
        byte_we_o = '0;
        line_wr_o = merged_line;
        if (state == LOOKUP && hit && is_store) begin
            wr_way_o = hit_way;
            tag_we_o = 1'b1;
            byte_we_o = store_be;
            line_wr_o = store_line;
        end else if (state == REFILL_WAIT && wb.refill_valid) begin
            tag_we_o = 1'b1;
            byte_we_o = '1;
        end
    end

    assign data_ok_o = (state == LOOKUP && hit) || (state == REFILL_WAIT && wb.refill_valid);
    assign rdata_o = (state == LOOKUP) ? hit_line[word_sel*DATA_W +: DATA_W]
                                       : merged_line[word_sel*DATA_W +: DATA_W];

    assign wb.push = (state == EVICT) && victim_dirty && !wb.full;
    assign wb.push_addr = {victim_tag.tag, addr_index(req_addr), {OFFSET_W{1'b0}}};
    assign wb.push_data = line_rd_i[victim_way];
    assign wb.refill_req = (state == REFILL_REQ) || (state == REFILL_WAIT);
    assign wb.refill_addr = line_addr(req_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            lfsr <= 16'hace1;
        end else begin
            // x^16 + x^14 + x^13 + x^11 + 1
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            case (state)
                IDLE: if (valid_i && init_done_i) state <= LOOKUP;
                LOOKUP: state <= hit ? IDLE : EVICT;
                EVICT: if (!(victim_dirty && wb.full)) state <= REFILL_REQ;
                // read goes out only after the buffer has drained
                REFILL_REQ: if (!wb.head_valid) state <= REFILL_WAIT;
                REFILL_WAIT: if (wb.refill_valid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && valid_i) begin
            req_addr <= addr_i;
            req_wstrb <= wstrb_i;
            req_wdata <= wdata_i;
        end
        if (state == LOOKUP) begin
            victim_way <= lfsr[0];
        end
    end

endmodule

// File: writeback_fifo.sv
`timescale 1ns/1ps

module writeback_fifo #(
    parameter int WB_DEPTH = dcache_pkg::WB_DEPTH
) (
    input logic clk,
    input logic rst,
    wb_if.fifo  wb
);
    import dcache_pkg::*;

    localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;

    logic [ADDR_W-1:0] addr_mem [WB_DEPTH];
    line_t data_mem [WB_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;

    assign wb.full = count == (PTR_W + 1)'(WB_DEPTH);
    assign wb.head_valid = count != '0;
    assign wb.head_addr = addr_mem[rd_ptr];
    assign wb.head_data = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wb.push) begin
                wr_ptr <= (wr_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (wb.pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(wb.push) - (PTR_W + 1)'(wb.pop);
        end
    end

    always_ff @(posedge clk) begin
        if (wb.push) begin
            addr_mem[wr_ptr] <= wb.push_addr;
            data_mem[wr_ptr] <= wb.push_data;
        end
    end

endmodule

// File: mem_port.sv
`timescale 1ns/1ps

module mem_port (
    input  logic                            clk,
    input  logic                            rst,
    wb_if.port                              wb,
    output logic                            mem_req_o,
    output logic                            mem_we_o,
    output logic [dcache_pkg::ADDR_W-1:0]   mem_addr_o,
    output dcache_pkg::line_t               mem_wdata_o,
    input  logic                            mem_rdy_i,
    input  logic                            mem_rvalid_i,
    input  logic                            mem_bvalid_i,
    input  dcache_pkg::line_t               mem_rdata_i
);

    // busy_we tells which response ends the one transaction in flight
    logic busy;
    logic busy_we;

    // buffered writebacks win over the refill read
    assign mem_req_o = !busy && (wb.head_valid || wb.refill_req);
    assign mem_we_o = !busy && wb.head_valid;
    assign mem_addr_o = wb.head_valid ? wb.head_addr : wb.refill_addr;
    assign mem_wdata_o = wb.head_data;

    assign wb.pop = mem_req_o && mem_we_o && mem_rdy_i;
    assign wb.refill_valid = busy && !busy_we && mem_rvalid_i;
    assign wb.refill_data = mem_rdata_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            busy_we <= 1'b0;
        end else if (mem_req_o && mem_rdy_i) begin
            busy <= 1'b1;
            busy_we <= mem_we_o;
        end else if (busy && (busy_we ? mem_bvalid_i : mem_rvalid_i)) begin
            busy <= 1'b0;
        end
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int NWAY = dcache_pkg::NWAY,
    parameter int NSET = dcache_pkg::NSET,
    parameter int WB_DEPTH = dcache_pkg::WB_DEPTH
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            valid_i,
    input  logic [dcache_pkg::ADDR_W-1:0]   addr_i,
    input  logic [3:0]                      wstrb_i,
    input  logic [dcache_pkg::DATA_W-1:0]   wdata_i,
    output logic                            data_ok_o,
    output logic [dcache_pkg::DATA_W-1:0]   rdata_o,
    output logic                            mem_req_o,
    output logic                            mem_we_o,
    output logic [dcache_pkg::ADDR_W-1:0]   mem_addr_o,
    output dcache_pkg::line_t               mem_wdata_o,
    input  logic                            mem_rdy_i,
    input  logic                            mem_rvalid_i,
    input  logic                            mem_bvalid_i,
    input  dcache_pkg::line_t               mem_rdata_i
);
    import dcache_pkg::*;

    logic [INDEX_W-1:0] rd_index;
    tag_entry_t [NWAY-1:0] tag_rd;
    line_t [NWAY-1:0] line_rd;
    logic wr_way;
    logic [INDEX_W-1:0] wr_index;
    logic tag_we;
    tag_entry_t tag_wr;
    logic [LINE_W/8-1:0] byte_we;
    line_t line_wr;
    logic init_done;

    wb_if wb_bus ();

    cache_store #(
        .NWAY(NWAY),
        .NSET(NSET)
    ) cache_store_i (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .tag_rd_o   (tag_rd),
        .line_rd_o  (line_rd),
        .wr_way_i   (wr_way),
        .wr_index_i (wr_index),
        .tag_we_i   (tag_we),
        .tag_wr_i   (tag_wr),
        .byte_we_i  (byte_we),
        .line_wr_i  (line_wr),
        .init_done_o(init_done)
    );

    dcache_ctrl dcache_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (valid_i),
        .addr_i     (addr_i),
        .wstrb_i    (wstrb_i),
        .wdata_i    (wdata_i),
        .data_ok_o  (data_ok_o),
        .rdata_o    (rdata_o),
        .rd_index_o (rd_index),
        .tag_rd_i   (tag_rd),
        .line_rd_i  (line_rd),
        .wr_way_o   (wr_way),
        .wr_index_o (wr_index),
        .tag_we_o   (tag_we),
        .tag_wr_o   (tag_wr),
        .byte_we_o  (byte_we),
        .line_wr_o  (line_wr),
        .init_done_i(init_done),
        .wb         (wb_bus.ctrl)
    );

    writeback_fifo #(
        .WB_DEPTH(WB_DEPTH)
    ) writeback_fifo_i (
        .clk(clk),
        .rst(rst),
        .wb (wb_bus.fifo)
    );

    mem_port mem_port_i (
        .clk         (clk),
        .rst         (rst),
        .wb          (wb_bus.port),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdy_i   (mem_rdy_i),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_bvalid_i(mem_bvalid_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

// File: dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            valid_i,
    input  logic [dcache_pkg::ADDR_W-1:0]   addr_i,
    input  logic [3:0]                      wstrb_i,
    input  logic [dcache_pkg::DATA_W-1:0]   wdata_i,
    input  logic                            data_ok_i,
    input  logic [dcache_pkg::DATA_W-1:0]   rdata_i,
    input  logic                            mem_req_i,
    input  logic                            mem_we_i,
    input  logic [dcache_pkg::ADDR_W-1:0]   mem_addr_i,
    input  dcache_pkg::line_t               mem_wdata_i,
    input  logic                            mem_rdy_i,
    input  logic                            mem_rvalid_i,
    input  logic                            mem_bvalid_i,
    output int                              value_errors_o,
    output int                              protocol_errors_o,
    output int                              answered_o
);
    import dcache_pkg::*;

    // flat word model over tag 0-3, index 0-3, word 0-3
    logic [DATA_W-1:0] model [64];
    logic pending;
    logic seen_valid;
    logic mem_busy;
    logic [ADDR_W-1:0] req_addr;
    logic [3:0] req_wstrb;
    logic [DATA_W-1:0] req_wdata;

    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return (a * 32'h9e37_79b9) ^ 32'hc3a5_0ff0;
    endfunction

    function automatic logic [5:0] word_slot(input logic [ADDR_W-1:0] a);
        return {a[13:12], a[5:4], a[3:2]};
    endfunction

    always @(posedge clk) begin
        logic [5:0] slot;
        line_t exp_line;
        if (rst) begin
            pending = 1'b0;
            seen_valid = 1'b0;
            mem_busy = 1'b0;
            value_errors_o = 0;
            protocol_errors_o = 0;
            answered_o = 0;
            for (int s = 0; s < 64; s++) begin
                model[s] = fill_word({18'b0, 2'(s >> 4), 6'b0, 2'(s >> 2), 2'(s), 2'b0});
            end
        end else begin
            if (!seen_valid && (data_ok_i || mem_req_i)) begin
                $display("%0t: DUT output went high before the first request", $time);
                protocol_errors_o++;
            end
            if (data_ok_i && !pending) begin
                $display("%0t: data_ok_o arrived with no open request", $time);
                protocol_errors_o++;
            end else if (data_ok_i) begin
                slot = word_slot(req_addr);
                if (req_wstrb == 4'b0 && rdata_i !== model[slot]) begin
                    $display("Fail %0t: load of %h returned %h, expected %h",
                             $time, req_addr, rdata_i, model[slot]);
                    value_errors_o++;
                end
                for (int b = 0; b < 4; b++) begin
                    if (req_wstrb[b]) begin
                        model[slot][8*b +: 8] = req_wdata[8*b +: 8];
                    end
                end
                pending = 1'b0;
                answered_o++;
            end
            if (valid_i) begin
                if (pending) begin
                    $display("%0t: valid_i raised while a request was still open", $time);
                    protocol_errors_o++;
                end
                pending = 1'b1;
                seen_valid = 1'b1;
                req_addr = addr_i;
                req_wstrb = wstrb_i;
                req_wdata = wdata_i;
            end
            if (mem_rvalid_i || mem_bvalid_i) begin
                mem_busy = 1'b0;
            end
            if (mem_req_i && mem_rdy_i) begin
                if (mem_busy) begin
                    $display("%0t: memory request accepted while another was outstanding",
                             $time);
                    protocol_errors_o++;
                end
                // only line-aligned addresses inside the test range are legal
                if ((mem_addr_i & ~32'h0000_3030) != '0) begin
                    $display("%0t: memory address %h is not a line in the test range",
                             $time, mem_addr_i);
                    protocol_errors_o++;
                end else if (mem_we_i) begin
                    for (int w = 0; w < 4; w++) begin
                        exp_line[32*w +: 32] = model[{mem_addr_i[13:12], mem_addr_i[5:4], 2'(w)}];
                    end
                    if (mem_wdata_i !== exp_line) begin
                        $display("Fail %0t: writeback of %h carries %h, expected %h",
                                 $time, mem_addr_i, mem_wdata_i, exp_line);
                        value_errors_o++;
                    end
                end
                mem_busy = 1'b1;
            end
        end
    end

endmodule

// File: dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam logic [31:0] SEED = 32'h2c93_86ca;
    localparam int N_REQ = 400;
    localparam int RESET_CYCLES = 8;
    localparam int INIT_WAIT = 300;
    localparam int REQ_CYCLES = 40;

    logic clk;
    logic rst;
    logic valid_i;
    logic [ADDR_W-1:0] addr_i;
    logic [3:0] wstrb_i;
    logic [DATA_W-1:0] wdata_i;
    logic data_ok_o;
    logic [DATA_W-1:0] rdata_o;
    logic mem_req_o;
    logic mem_we_o;
    logic [ADDR_W-1:0] mem_addr_o;
    line_t mem_wdata_o;
    logic mem_rdy_i;
    logic mem_rvalid_i;
    logic mem_bvalid_i;
    line_t mem_rdata_i;
    int value_errors;
    int protocol_errors;
    int answered;

    dcache_top dcache_top_i (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid_i),
        .addr_i      (addr_i),
        .wstrb_i     (wstrb_i),
        .wdata_i     (wdata_i),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdy_i   (mem_rdy_i),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_bvalid_i(mem_bvalid_i),
        .mem_rdata_i (mem_rdata_i)
    );

    dcache_checker checker_i (
        .clk              (clk),
        .rst              (rst),
        .valid_i          (valid_i),
        .addr_i           (addr_i),
        .wstrb_i          (wstrb_i),
        .wdata_i          (wdata_i),
        .data_ok_i        (data_ok_o),
        .rdata_i          (rdata_o),
        .mem_req_i        (mem_req_o),
        .mem_we_i         (mem_we_o),
        .mem_addr_i       (mem_addr_o),
        .mem_wdata_i      (mem_wdata_o),
        .mem_rdy_i        (mem_rdy_i),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_bvalid_i     (mem_bvalid_i),
        .value_errors_o   (value_errors),
        .protocol_errors_o(protocol_errors),
        .answered_o       (answered)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(inout logic [31:0] state, input int count,
                             output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            state = lfsr_step(state);
            bits = {bits[30:0], state[0]};
        end
    endtask

    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return (a * 32'h9e37_79b9) ^ 32'hc3a5_0ff0;
    endfunction

    function automatic logic [3:0] line_slot(input logic [ADDR_W-1:0] a);
        return {a[13:12], a[5:4]};
    endfunction

    task automatic print_counts();
        $display("errors: %0d value, %0d protocol; %0d of %0d requests answered",
                 value_errors, protocol_errors, answered, N_REQ);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : stimulus
        logic [31:0] state;
        logic [31:0] r;
        logic is_store;
        logic [1:0] size;
        logic [1:0] lane;
        logic [3:0] strb;
        logic [ADDR_W-1:0] a;
        rst = 1'b1;
        valid_i = 1'b0;
        addr_i = '0;
        wstrb_i = '0;
        wdata_i = '0;
        state = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        // tag arrays are swept clear during this wait
        repeat (INIT_WAIT) @(posedge clk);
        for (int n = 0; n < N_REQ; n++) begin
            take_bits(state, 1, r);
            is_store = r[0];
            take_bits(state, 6, r);
            a = {18'b0, r[5:4], 6'b0, r[3:2], r[1:0], 2'b0};
            take_bits(state, 2, r);
            size = r[1:0];
            take_bits(state, 2, r);
            lane = r[1:0];
            case (size)
                2'd0: begin
                    strb = 4'b0001 << lane;
                    a[1:0] = lane;
                end
                2'd1: begin
                    strb = 4'b0011 << {lane[0], 1'b0};
                    a[1:0] = {lane[0], 1'b0};
                end
                default: strb = 4'b1111;
            endcase
            take_bits(state, 32, r);
            #1;
            valid_i = 1'b1;
            addr_i = a;
            wstrb_i = is_store ? strb : 4'b0;
            wdata_i = r;
            @(posedge clk);
            #1 valid_i = 1'b0;
            do @(posedge clk); while (!data_ok_o);
        end
        repeat (20) @(posedge clk);
        print_counts();
        if (value_errors == 0 && protocol_errors == 0 && answered == N_REQ) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // memory with random ready and a 1 to 8 cycle response delay
    initial begin : mem_responder
        logic [31:0] state;
        logic [31:0] r;
        line_t mem_lines [16];
        logic acc;
        logic acc_we;
        logic [ADDR_W-1:0] acc_addr;
        line_t acc_data;
        logic pend;
        logic pend_we;
        logic [ADDR_W-1:0] pend_addr;
        int delay;
        mem_rdy_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_bvalid_i = 1'b0;
        mem_rdata_i = '0;
        state = SEED;
        pend = 1'b0;
        pend_we = 1'b0;
        pend_addr = '0;
        delay = 0;
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 4; w++) begin
                mem_lines[s][32*w +: 32] =
                    fill_word({18'b0, 2'(s >> 2), 6'b0, 2'(s), 2'(w), 2'b0});
            end
        end
        forever begin
            @(posedge clk);
            acc = mem_req_o && mem_rdy_i;
            acc_we = mem_we_o;
            acc_addr = mem_addr_o;
            acc_data = mem_wdata_o;
            #1;
            mem_rvalid_i = 1'b0;
            mem_bvalid_i = 1'b0;
            if (pend && delay == 0) begin
                pend = 1'b0;
                if (pend_we) begin
                    mem_bvalid_i = 1'b1;
                end else begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i = mem_lines[line_slot(pend_addr)];
                end
            end else if (pend) begin
                delay--;
            end
            if (acc === 1'b1) begin
                pend = 1'b1;
                pend_we = acc_we;
                pend_addr = acc_addr;
                if (acc_we) begin
                    mem_lines[line_slot(acc_addr)] = acc_data;
                end
                take_bits(state, 3, r);
                delay = int'(r[2:0]);
            end
            take_bits(state, 2, r);
            mem_rdy_i = (r[1:0] != 2'b00);
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + INIT_WAIT + N_REQ * REQ_CYCLES) @(posedge clk);
        $display("watchdog: requests still open when the time limit ran out");
        print_counts();
        $display("sim failed");
        $finish;
    end

endmodule

// File: dcache_top.f
dcache_pkg.sv
wb_if.sv
cache_store.sv
dcache_ctrl.sv
writeback_fifo.sv
mem_port.sv
dcache_top.sv
dcache_checker.sv
dcache_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := dcache_tb
FILELIST   := dcache_top.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
